// File: uart_aes_settings.svh
// ====================
// Shared constants for the UART front end of a 128-bit AES core
// Clock divider assumes 100 MHz and 9600 baud
// ====================
`ifndef UART_AES_SETTINGS_SVH
`define UART_AES_SETTINGS_SVH

// Clocks per serial bit period
`define UA_CLKS_PER_BIT 10416

// Header byte plus 16 key bytes plus 16 data bytes
`define UA_CMD_BYTES 33

// Bytes in one 128-bit block
`define UA_BLOCK_BYTES 16

// Byte count at which the core enable rises
`define UA_EN_BYTE 30

`endif

// File: uart_aes_pkg.sv
// ====================
// Types shared by the UART command front end
// ====================
package uart_aes_pkg;

  typedef logic [7:0]   byte_t;
  typedef logic [127:0] block_t;

  // First byte of a command frame
  typedef struct packed {
    logic [6:0] reserved;
    logic       aes_reset;  // Request one-cycle core reset
  } cmd_header_t;

  // Same received byte seen as header or as raw payload
  typedef union packed {
    byte_t       raw;
    cmd_header_t hdr;
  } cmd_byte_u;

  // Everything driven into the AES core
  typedef struct packed {
    logic   rstn;
    logic   en;
    logic   kdrdy;
    block_t kin;
    block_t din;
  } aes_ctrl_t;

  typedef struct packed {
    logic  valid;  // One-cycle strobe
    byte_t data;
  } rx_byte_t;

endpackage

// File: uart_rx.sv
// ====================
// 8N1 receiver with no back-pressure. CLKS_PER_BIT must be 4 or more
// Bytes with a low stop bit are dropped
// ====================
`include "uart_aes_settings.svh"

module uart_rx import uart_aes_pkg::*; #(
  parameter int CLKS_PER_BIT = `UA_CLKS_PER_BIT
) (
  input  logic     CLK,
  input  logic     NRST,
  input  logic     rx,
  output rx_byte_t rx_byte
);

  localparam int CW = $clog2(CLKS_PER_BIT);
  localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] BIT_HALF = CW'(CLKS_PER_BIT / 2);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e     state;
  logic [2:0]    rx_sync;  // Two sync stages plus one for edge detect
  logic [CW-1:0] bit_cnt;
  logic [2:0]    bit_idx;
  byte_t         shift_q;
  logic          valid_q;
  logic          line;
  logic          fall;

  assign line = rx_sync[1];
  assign fall = rx_sync[2] & ~rx_sync[1];

  // Idle line is high
  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      rx_sync <= '1;
    end else begin
      rx_sync <= {rx_sync[1:0], rx};
    end
  end

  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      state   <= RX_IDLE;
      bit_cnt <= '0;
      bit_idx <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      bit_cnt <= bit_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          bit_cnt <= '0;
          if (fall) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // Mid start bit, later samples land mid-bit
          if (bit_cnt == BIT_HALF) begin
            bit_cnt <= '0;
            bit_idx <= '0;
            state   <= line ? RX_IDLE : RX_DATA;  // High here means a glitch
          end
        end
        RX_DATA: begin
          if (bit_cnt == BIT_LAST) begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (bit_cnt == BIT_LAST) begin
            valid_q <= line;  // Framing error drops the byte
            state   <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge CLK) begin
    if (state == RX_DATA && bit_cnt == BIT_LAST) begin
      shift_q <= {line, shift_q[7:1]};
    end
  end

  assign rx_byte.valid = valid_q;
  assign rx_byte.data  = shift_q;

endmodule

// File: cmd_assembler.sv
// ====================
// Expects 33-byte frames back to back with no resync
// A lost byte shifts every later frame
// ====================
`include "uart_aes_settings.svh"

module cmd_assembler import uart_aes_pkg::*; (
  input  logic      CLK,
  input  logic      NRST,
  input  rx_byte_t  rx_byte,
  output aes_ctrl_t aes_ctrl
);

  localparam int BW = $clog2(`UA_CMD_BYTES);
  localparam int IW = $clog2(`UA_BLOCK_BYTES);
  localparam logic [BW-1:0] LAST_BYTE = BW'(`UA_CMD_BYTES - 1);
  localparam logic [BW-1:0] EN_BYTE   = BW'(`UA_EN_BYTE);
  localparam logic [BW-1:0] KEY_LAST  = BW'(`UA_BLOCK_BYTES);

  cmd_byte_u     rx_word;
  cmd_header_t   hdr_q;
  logic          hdr_stb;  // High the cycle after the header byte
  logic [BW-1:0] byte_cnt;
  logic [IW-1:0] key_idx;
  logic [IW-1:0] data_idx;
  logic          en_q;
  logic          kdrdy_q;
  block_t        kin_q;
  block_t        din_q;

  assign rx_word.raw = rx_byte.data;
  assign key_idx     = IW'(byte_cnt - BW'(1));
  assign data_idx    = IW'(byte_cnt - BW'(`UA_BLOCK_BYTES + 1));

  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      byte_cnt <= '0;
      hdr_stb  <= 1'b0;
      en_q     <= 1'b0;
      kdrdy_q  <= 1'b0;
      kin_q    <= '0;
      din_q    <= '0;
    end else begin
      hdr_stb <= 1'b0;
      kdrdy_q <= 1'b0;
      if (rx_byte.valid) begin
        if (byte_cnt == LAST_BYTE) begin
          byte_cnt <= '0;
          kdrdy_q  <= 1'b1;  // Frame complete
        end else begin
          byte_cnt <= byte_cnt + 1'b1;
        end
        if (byte_cnt == EN_BYTE) begin
          en_q <= 1'b1;  // Sticky until NRST
        end
        if (byte_cnt == '0) begin
          hdr_stb <= 1'b1;
        end else if (byte_cnt <= KEY_LAST) begin
          kin_q[8*key_idx +: 8] <= rx_word.raw;
        end else begin
          din_q[8*data_idx +: 8] <= rx_word.raw;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rx_byte.valid && byte_cnt == '0) begin
      hdr_q <= rx_word.hdr;
    end
  end

  assign aes_ctrl.rstn  = ~(hdr_stb & hdr_q.aes_reset);
  assign aes_ctrl.en    = en_q;
  assign aes_ctrl.kdrdy = kdrdy_q;
  assign aes_ctrl.kin   = kin_q;
  assign aes_ctrl.din   = din_q;

endmodule

// File: uart_tx.sv
// ====================
// 8N1 transmitter. tx_valid is accepted only when idle
// ====================
`include "uart_aes_settings.svh"

module uart_tx import uart_aes_pkg::*; #(
  parameter int CLKS_PER_BIT = `UA_CLKS_PER_BIT
) (
  input  logic  CLK,
  input  logic  NRST,
  input  logic  tx_valid,
  input  byte_t tx_data,
  output logic  tx_credit,
  output logic  tx
);

  localparam int CW = $clog2(CLKS_PER_BIT);
  localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

  tx_state_e     state;
  logic [CW-1:0] bit_cnt;
  logic [2:0]    bit_idx;
  byte_t         shift_q;
  logic          tx_q;
  logic          credit_q;
  logic          bit_end;

  assign bit_end = (bit_cnt == BIT_LAST);

  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      state    <= TX_IDLE;
      bit_cnt  <= '0;
      bit_idx  <= '0;
      tx_q     <= 1'b1;
      credit_q <= 1'b0;
    end else begin
      credit_q <= 1'b0;
      bit_cnt  <= bit_cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          bit_cnt <= '0;
          if (tx_valid) begin
            tx_q  <= 1'b0;  // Start bit
            state <= TX_START;
          end
        end
        TX_START, TX_DATA: begin
          if (bit_end) begin
            bit_cnt <= '0;
            if (state == TX_START) begin
              bit_idx <= '0;
              tx_q    <= shift_q[0];
              state   <= TX_DATA;
            end else if (bit_idx == 3'd7) begin
              tx_q  <= 1'b1;  // Stop bit
              state <= TX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx_q    <= shift_q[0];
            end
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            credit_q <= 1'b1;  // Ready for the next byte
            state    <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == TX_IDLE && tx_valid) begin
      shift_q <= tx_data;
    end else if (state != TX_IDLE && bit_end) begin
      shift_q <= {1'b1, shift_q[7:1]};
    end
  end

  assign tx        = tx_q;
  assign tx_credit = credit_q;

endmodule

// File: result_serializer.sv
// ====================
// A dvld_aes rise while bytes are still being issued is ignored
// ====================
`include "uart_aes_settings.svh"

module result_serializer import uart_aes_pkg::*; (
  input  logic   CLK,
  input  logic   NRST,
  input  block_t dout_aes,
  input  logic   dvld_aes,
  input  logic   tx_credit,
  output logic   tx_valid,
  output byte_t  tx_data
);

  localparam int IW = $clog2(`UA_BLOCK_BYTES);
  localparam logic [IW-1:0] LAST_IDX = IW'(`UA_BLOCK_BYTES - 1);

  logic          dvld_q;
  logic          busy;
  logic          credit;  // One byte in flight at most
  logic          valid_q;
  logic [IW-1:0] byte_idx;
  block_t        block_q;
  byte_t         data_q;
  logic          capture;
  logic          issue;

  assign capture = dvld_aes & ~dvld_q & ~busy;
  assign issue   = busy & credit;

  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      dvld_q   <= 1'b0;
      busy     <= 1'b0;
      credit   <= 1'b1;
      valid_q  <= 1'b0;
      byte_idx <= '0;
    end else begin
      dvld_q  <= dvld_aes;
      valid_q <= issue;
      if (issue) begin
        credit <= 1'b0;
      end else if (tx_credit) begin
        credit <= 1'b1;
      end
      if (capture) begin
        busy     <= 1'b1;
        byte_idx <= '0;
      end else if (issue) begin
        byte_idx <= byte_idx + 1'b1;
        if (byte_idx == LAST_IDX) begin
          busy <= 1'b0;  // Last byte handed over
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (capture) begin
      block_q <= dout_aes;
    end
    if (issue) begin
      data_q <= block_q[8*byte_idx +: 8];  // Byte 0 first
    end
  end

  assign tx_valid = valid_q;
  assign tx_data  = data_q;

endmodule

// File: uart_aes_if.sv
// ====================
// UART command front end for a 128-bit AES encryption core
// ====================
`include "uart_aes_settings.svh"

module uart_aes_if import uart_aes_pkg::*; #(
  parameter int CLKS_PER_BIT = `UA_CLKS_PER_BIT
) (
  input  logic   CLK,
  input  logic   NRST,
  input  logic   rx_uart,
  input  block_t dout_aes,
  input  logic   dvld_aes,
  output logic   tx_uart,
  output logic   en_aes,
  output logic   rstn_aes,
  output logic   kdrdy_aes,
  output block_t kin_aes,
  output block_t din_aes
);

  rx_byte_t  rx_byte;
  aes_ctrl_t aes_ctrl;
  logic      tx_valid;
  logic      tx_credit;
  byte_t     tx_data;

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
    .CLK    (CLK),
    .NRST   (NRST),
    .rx     (rx_uart),
    .rx_byte(rx_byte)
  );

  cmd_assembler u_cmd (
    .CLK     (CLK),
    .NRST    (NRST),
    .rx_byte (rx_byte),
    .aes_ctrl(aes_ctrl)
  );

  result_serializer u_ser (
    .CLK      (CLK),
    .NRST     (NRST),
    .dout_aes (dout_aes),
    .dvld_aes (dvld_aes),
    .tx_credit(tx_credit),
    .tx_valid (tx_valid),
    .tx_data  (tx_data)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
    .CLK      (CLK),
    .NRST     (NRST),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .tx_credit(tx_credit),
    .tx       (tx_uart)
  );

  // Core side control
  assign rstn_aes  = aes_ctrl.rstn;
  assign en_aes    = aes_ctrl.en;
  assign kdrdy_aes = aes_ctrl.kdrdy;
  assign kin_aes   = aes_ctrl.kin;
  assign din_aes   = aes_ctrl.din;

endmodule

// File: tb_uart_aes.sv
// ====================
// Runs the DUT at 16 clocks per bit, one command or result at a time
// ====================
`include "uart_aes_settings.svh"

module tb_uart_aes import uart_aes_pkg::*; ();

  localparam int CPB            = 16;
  localparam int NB             = `UA_BLOCK_BYTES;
  localparam int TIMEOUT_CYCLES = 40000;  // About twice the traffic

  logic   CLK;
  logic   NRST;
  logic   rx_uart;
  block_t dout_aes;
  logic   dvld_aes;
  logic   tx_uart;
  logic   en_aes;
  logic   rstn_aes;
  logic   kdrdy_aes;
  block_t kin_aes;
  block_t din_aes;

  integer seed;
  int     val_errs     = 0;
  int     misc_errs    = 0;
  int     cycle_cnt    = 0;
  int     kdrdy_cnt    = 0;
  int     rstn_low_cnt = 0;
  int     rstn_low_kd  = 0;  // kdrdy count seen at the last rstn_aes low
  int     tx_byte_cnt  = 0;
  logic   en_seen      = 1'b0;
  block_t exp_kin;
  block_t exp_din;
  byte_t  exp_q[$];

  uart_aes_if #(.CLKS_PER_BIT(CPB)) UUT (
    .CLK      (CLK),
    .NRST     (NRST),
    .rx_uart  (rx_uart),
    .dout_aes (dout_aes),
    .dvld_aes (dvld_aes),
    .tx_uart  (tx_uart),
    .en_aes   (en_aes),
    .rstn_aes (rstn_aes),
    .kdrdy_aes(kdrdy_aes),
    .kin_aes  (kin_aes),
    .din_aes  (din_aes)
  );

  always #20 CLK = ~CLK;

  // Byte i of a block sits in bits 8i+7 down to 8i
  function automatic byte_t expected_tx_byte(input block_t blk, input int i);
    return blk[8*i +: 8];
  endfunction

  task automatic report_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
    $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    val_errs++;
  endtask

  // Start bit, 8 data bits LSB first, stop bit
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx_uart = frame[i];
      repeat (CPB) @(posedge CLK);
      #2;
    end
  endtask

  task automatic send_cmd(input byte_t hdr, input bit first);
    byte_t frame [`UA_CMD_BYTES];
    int    kd_before;
    int    low_before;
    kd_before  = kdrdy_cnt;
    low_before = rstn_low_cnt;
    frame[0]   = hdr;
    for (int i = 1; i < `UA_CMD_BYTES; i++) begin
      frame[i] = byte_t'($random(seed));
    end
    for (int i = 0; i < NB; i++) begin
      exp_kin[8*i +: 8] = frame[1 + i];
      exp_din[8*i +: 8] = frame[1 + NB + i];
    end
    for (int i = 0; i < `UA_CMD_BYTES; i++) begin
      if (first && i == `UA_EN_BYTE && en_aes !== 1'b0) begin
        report_value("en_aes", en_aes, 1'b0);  // Too early
      end
      if (first && i == `UA_EN_BYTE + 1 && en_aes !== 1'b1) begin
        report_value("en_aes", en_aes, 1'b1);  // Too late
      end
      send_byte(frame[i]);
    end
    while (kdrdy_cnt == kd_before) @(posedge CLK);
    repeat (CPB) @(posedge CLK);
    #2;
    if (kdrdy_cnt != kd_before + 1) begin
      $display("kdrdy_aes was high %0d cycles for one command", kdrdy_cnt - kd_before);
      misc_errs++;
    end
    if (kin_aes !== exp_kin) report_value("kin_aes", kin_aes, exp_kin);
    if (din_aes !== exp_din) report_value("din_aes", din_aes, exp_din);
    if (en_aes !== 1'b1) report_value("en_aes", en_aes, 1'b1);
    if (hdr[0] && rstn_low_cnt != low_before + 1) begin
      $display("rstn_aes was low %0d cycles, expected one", rstn_low_cnt - low_before);
      misc_errs++;
    end else if (hdr[0] && rstn_low_kd != kd_before) begin
      $display("rstn_aes pulse did not come before kdrdy_aes");
      misc_errs++;
    end else if (!hdr[0] && rstn_low_cnt != low_before) begin
      $display("rstn_aes went low for a command without the reset bit");
      misc_errs++;
    end
  endtask

  task automatic queue_result(input block_t blk);
    for (int i = 0; i < NB; i++) begin
      exp_q.push_back(expected_tx_byte(blk, i));
    end
  endtask

  task automatic raise_dvld(input block_t blk);
    dout_aes = blk;
    dvld_aes = 1'b1;
    repeat (2) @(posedge CLK);
    #2;
    dvld_aes = 1'b0;
  endtask

  task automatic wait_tx_count(input int n);
    while (tx_byte_cnt < n) @(posedge CLK);
    #2;
  endtask

  // Core side strobes, sampled mid cycle
  always @(negedge CLK) begin
    if (NRST === 1'b1) begin
      if (kdrdy_aes === 1'b1) begin
        kdrdy_cnt++;
        if (en_aes !== 1'b1) report_value("en_aes", en_aes, 1'b1);
      end
      if (rstn_aes !== 1'b1) begin
        rstn_low_cnt++;
        rstn_low_kd = kdrdy_cnt;
      end
      if (en_aes === 1'b1) begin
        en_seen = 1'b1;
      end else if (en_seen) begin
        $display("en_aes fell at %0t after it had risen", $time);
        misc_errs++;
      end
    end
  end

  always begin : tx_monitor
    byte_t got;
    byte_t exp_b;
    @(negedge tx_uart);
    repeat (CPB / 2) @(negedge CLK);  // Mid start bit
    if (tx_uart !== 1'b0) begin
      $display("Start bit on tx_uart was not low at %0t", $time);
      misc_errs++;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (CPB) @(negedge CLK);
      got[i] = tx_uart;
    end
    repeat (CPB) @(negedge CLK);
    if (tx_uart !== 1'b1) begin
      $display("Stop bit on tx_uart was not high at %0t", $time);
      misc_errs++;
    end
    if (exp_q.size() == 0) begin
      $display("Unexpected byte %h on tx_uart at %0t", got, $time);
      misc_errs++;
    end else begin
      exp_b = exp_q.pop_front();
      if (got !== exp_b) report_value("tx_uart byte", got, exp_b);
    end
    tx_byte_cnt++;
  end

  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run hung, stopped after %0d cycles", cycle_cnt);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    block_t res_a;
    block_t res_b;
    block_t res_c;
    seed     = 39;
    CLK      = 1'b0;
    NRST     = 1'b0;
    rx_uart  = 1'b1;
    dout_aes = '0;
    dvld_aes = 1'b0;
    repeat (3) @(posedge CLK);
    #2;
    NRST = 1'b1;
    repeat (4) @(posedge CLK);
    #2;
    if (tx_uart !== 1'b1) report_value("tx_uart", tx_uart, 1'b1);
    if (rstn_aes !== 1'b1) report_value("rstn_aes", rstn_aes, 1'b1);
    if (en_aes !== 1'b0) report_value("en_aes", en_aes, 1'b0);
    if (kdrdy_aes !== 1'b0) report_value("kdrdy_aes", kdrdy_aes, 1'b0);
    if (kin_aes !== '0) report_value("kin_aes", kin_aes, '0);
    if (din_aes !== '0) report_value("din_aes", din_aes, '0);
    send_cmd(8'h00, 1'b1);
    send_cmd(8'h01, 1'b0);  // Core reset requested
    // Short low glitch must not start a byte
    rx_uart = 1'b0;
    repeat (4) @(posedge CLK);
    #2;
    rx_uart = 1'b1;
    repeat (2 * CPB) @(posedge CLK);
    #2;
    send_cmd(8'h00, 1'b0);
    res_a = {$random(seed), $random(seed), $random(seed), $random(seed)};
    res_b = {$random(seed), $random(seed), $random(seed), $random(seed)};
    res_c = {$random(seed), $random(seed), $random(seed), $random(seed)};
    queue_result(res_a);
    raise_dvld(res_a);
    repeat (10 * CPB) @(posedge CLK);
    #2;
    raise_dvld(res_b);  // Lands mid transmission
    wait_tx_count(NB);
    repeat (20 * CPB) @(posedge CLK);
    #2;
    queue_result(res_c);
    raise_dvld(res_c);
    wait_tx_count(2 * NB);
    repeat (20 * CPB) @(posedge CLK);
    #2;
    if (tx_byte_cnt != 2 * NB || exp_q.size() != 0) begin
      $display("tx_uart sent %0d bytes, expected %0d", tx_byte_cnt, 2 * NB);
      misc_errs++;
    end
    $display("Errors: %0d wrong values, %0d other failures", val_errs, misc_errs);
    if (val_errs + misc_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
uart_aes_pkg.sv
uart_rx.sv
cmd_assembler.sv
uart_tx.sv
result_serializer.sv
uart_aes_if.sv
tb_uart_aes.sv
